// File: Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module tb_cpu -f flist.f

sim:
	verilator --binary --timing --assert --top-module tb_cpu -Mdir obj_dir -f flist.f
	./obj_dir/Vtb_cpu | tee $(LOG)
	@if grep -q "^Testbench passed$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/control_decoder.sv
verilog/hazard_unit.sv
verilog/datapath.sv
verilog/cpu_top.sv
test/cpu_assert.sv
test/tb_cpu.sv

// File: test/cpu_assert.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_assert import cpu_pkg::*; (
        input wire logic      i_clk,
        input wire logic      i_reset_n,
        input wire dmem_req_t i_dmem,
        input wire logic      i_halted,
        input wire logic      i_output_valid
);

        // one data access per cycle
        assert property (@(posedge i_clk) disable iff (i_reset_n)
                !(i_dmem.read && i_dmem.write))
                else $error("data memory read and write asserted together");

        // halt is sticky
        assert property (@(posedge i_clk) disable iff (i_reset_n)
                i_halted |=> i_halted)
                else $error("halted dropped without reset");

        assert property (@(posedge i_clk)
                (i_reset_n && $past(i_reset_n)) |-> !i_output_valid)
                else $error("output valid high during reset");

endmodule

bind datapath cpu_assert u_cpu_assert (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_dmem         (o_dmem),
        .i_halted       (o_halted),
        .i_output_valid (o_output_valid)
);

`default_nettype wire

// File: test/tb_cpu.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

        localparam int NUM_TESTS = 5;
        localparam int MAX_PROG  = 16;
        localparam int MAX_OUTS  = 8;
        localparam int TIMEOUT   = 500;

        logic      clk;
        logic      reset_n;
        word_t     i_data;
        word_t     i_address;
        dmem_req_t dmem_req;
        word_t     d_rdata;
        word_t     output_port;
        logic      output_valid;
        logic      halted;
        word_t     num_inst;

        word_t     imem [256];
        word_t     dmem [256];
        dmem_req_t wr_req;

        // test table
        string     names     [NUM_TESTS];
        word_t     prog      [NUM_TESTS][MAX_PROG];
        int        prog_len  [NUM_TESTS];
        word_t     exp_outs  [NUM_TESTS][MAX_OUTS];
        int        n_outs    [NUM_TESTS];
        word_t     exp_num   [NUM_TESTS];
        int        mem_addr  [NUM_TESTS];   // -1 when nothing to check
        word_t     mem_val   [NUM_TESTS];

        int        errors;
        int        failed_tests;
        int        test_errs;
        logic [15:0] lfsr;

        cpu_top i_cpu_top (
                .i_clk          (clk),
                .i_reset_n      (reset_n),
                .i_i_data       (i_data),
                .o_i_address    (i_address),
                .o_dmem         (dmem_req),
                .i_d_rdata      (d_rdata),
                .o_output_port  (output_port),
                .o_output_valid (output_valid),
                .o_halted       (halted),
                .o_num_inst     (num_inst)
        );

        always #10 clk = ~clk;

        // ----------------------------------------
        // memory models
        // ----------------------------------------
        always @(negedge clk) begin
                i_data  <= imem[i_address[7:0]];
                // data only on a read strobe
                d_rdata <= (dmem_req.read === 1'b1) ? dmem[dmem_req.address[7:0]] : '0;
                wr_req  <= dmem_req;    // committed on the next rising edge
        end

        always @(posedge clk) begin
                if (wr_req.write === 1'b1) begin
                        dmem[wr_req.address[7:0]] = wr_req.wdata;
                end
        end

        // ----------------------------------------
        // encoders and lfsr
        // ----------------------------------------
        function automatic word_t rtype_word(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                             func_e f);
                return {RTYPE, rs, rt, rd, f};
        endfunction

        function automatic word_t itype_word(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                             logic [7:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic word_t jump_word(logic [11:0] target);
                return {JMP, target};
        endfunction

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_next(logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        task automatic random_imm(output logic [7:0] imm);
                imm = '0;
                for (int b = 0; b < 8; b++) begin
                        lfsr = lfsr_next(lfsr);
                        imm  = {imm[6:0], lfsr[0]};
                end
        endtask

        function automatic word_t sext8(logic [7:0] v);
                return {{8{v[7]}}, v};
        endfunction

        task automatic check(input logic cond, input string msg);
                assert (cond) else begin
                        $display("ERR %0t: %s", $time, msg);
                        errors++;
                        test_errs++;
                end
        endtask

        // ----------------------------------------
        // test table
        // ----------------------------------------
        task automatic build_table();
                logic [7:0] imm;
                word_t      sum;
                word_t      e0, e1, e2, e3;

                // adi chain with random immediates
                names[0] = "adi chain";
                sum = '0;
                for (int i = 0; i < 3; i++) begin
                        random_imm(imm);
                        sum = sum + sext8(imm);
                        prog[0][2*i]     = itype_word(ADI, (i == 0) ? 0 : 1, 1, imm);
                        prog[0][2*i + 1] = rtype_word(1, 0, 0, WWD);
                        exp_outs[0][i]   = sum;
                end
                prog[0][6] = rtype_word(0, 0, 0, HLT);
                prog_len[0] = 7;
                n_outs[0]   = 3;
                exp_num[0]  = 16'd7;
                mem_addr[0] = -1;

                // dependent alu ops that each stall
                names[1] = "dependent alu";
                e3 = 16'd5 + 16'hfffd;
                e0 = e3 - 16'd5;
                e1 = e0 & e3;
                e2 = e1 | e3;
                prog[1][0]  = itype_word(ADI, 0, 1, 8'h05);
                prog[1][1]  = itype_word(ADI, 0, 2, 8'hfd);
                prog[1][2]  = rtype_word(1, 2, 3, ADD);
                prog[1][3]  = rtype_word(3, 1, 0, SUB);
                prog[1][4]  = rtype_word(0, 3, 1, AND);
                prog[1][5]  = rtype_word(1, 3, 2, ORR);
                prog[1][6]  = rtype_word(3, 0, 0, WWD);
                prog[1][7]  = rtype_word(0, 0, 0, WWD);
                prog[1][8]  = rtype_word(1, 0, 0, WWD);
                prog[1][9]  = rtype_word(2, 0, 0, WWD);
                prog[1][10] = rtype_word(0, 0, 0, HLT);
                exp_outs[1][0] = e3;
                exp_outs[1][1] = e0;
                exp_outs[1][2] = e1;
                exp_outs[1][3] = e2;
                prog_len[1] = 11;
                n_outs[1]   = 4;
                exp_num[1]  = 16'd11;
                mem_addr[1] = -1;

                // store then load the same word
                names[2] = "store load";
                prog[2][0] = itype_word(ADI, 0, 1, 8'h12);
                prog[2][1] = itype_word(ADI, 0, 2, 8'hd7);
                prog[2][2] = itype_word(SWD, 1, 2, 8'h03);
                prog[2][3] = itype_word(LWD, 1, 3, 8'h03);
                prog[2][4] = rtype_word(3, 0, 0, WWD);
                prog[2][5] = rtype_word(0, 0, 0, HLT);
                exp_outs[2][0] = sext8(8'hd7);
                prog_len[2] = 6;
                n_outs[2]   = 1;
                exp_num[2]  = 16'd6;
                mem_addr[2] = 16'h12 + 3;
                mem_val[2]  = sext8(8'hd7);

                // taken and not-taken branches
                names[3] = "branches";
                prog[3][0]  = itype_word(ADI, 0, 1, 8'h07);
                prog[3][1]  = itype_word(ADI, 0, 2, 8'h07);
                prog[3][2]  = itype_word(BEQ, 1, 2, 8'h02);   // taken to 5
                prog[3][3]  = rtype_word(1, 0, 0, WWD);       // shadow
                prog[3][4]  = rtype_word(2, 0, 0, WWD);       // shadow
                prog[3][5]  = itype_word(BNE, 1, 2, 8'h01);   // falls through
                prog[3][6]  = itype_word(ADI, 0, 3, 8'h01);
                prog[3][7]  = itype_word(BNE, 1, 3, 8'h01);   // taken to 9
                prog[3][8]  = rtype_word(1, 0, 0, WWD);       // shadow
                prog[3][9]  = rtype_word(3, 0, 0, WWD);
                prog[3][10] = itype_word(BEQ, 1, 3, 8'h01);   // falls through
                prog[3][11] = rtype_word(2, 0, 0, WWD);
                prog[3][12] = rtype_word(0, 0, 0, HLT);
                exp_outs[3][0] = 16'd1;
                exp_outs[3][1] = 16'd7;
                prog_len[3] = 13;
                n_outs[3]   = 2;
                exp_num[3]  = 16'd10;
                mem_addr[3] = -1;

                names[4] = "jump";
                prog[4][0] = itype_word(ADI, 0, 1, 8'h09);
                prog[4][1] = jump_word(12'd3);
                prog[4][2] = rtype_word(1, 0, 0, WWD);        // skipped
                prog[4][3] = rtype_word(1, 0, 0, WWD);
                prog[4][4] = rtype_word(0, 0, 0, HLT);
                exp_outs[4][0] = 16'd9;
                prog_len[4] = 5;
                n_outs[4]   = 1;
                exp_num[4]  = 16'd4;
                mem_addr[4] = -1;
        endtask

        // ----------------------------------------
        // run loop
        // ----------------------------------------
        task automatic run_test(input int t);
                word_t seen [$];
                int    cycles;
                word_t num_at_halt;

                test_errs = 0;
                @(negedge clk);
                reset_n = 1'b1;
                for (int a = 0; a < 256; a++) begin
                        imem[a] = {4'hf, a[7:0], 4'hf};  // undecoded rtype fill
                        dmem[a] = {a[7:0], ~a[7:0]};
                end
                for (int i = 0; i < prog_len[t]; i++) begin
                        imem[i] = prog[t][i];
                end
                repeat (16) @(negedge clk);
                reset_n = 1'b0;

                cycles = 0;
                while (!halted && cycles < TIMEOUT) begin
                        @(negedge clk);
                        cycles++;
                        if (output_valid) seen.push_back(output_port);
                end
                if (!halted) begin
                        $display("test %0d timed out waiting for halt after %0d cycles",
                                 t, TIMEOUT);
                        errors++;
                        test_errs++;
                end
                num_at_halt = num_inst;

                // the pipeline must stay quiet once halted
                cycles = 0;
                while (cycles < 8) begin
                        @(negedge clk);
                        cycles++;
                        if (output_valid) seen.push_back(output_port);
                        check(halted, "halted dropped after hlt");
                end

                check(seen.size() == n_outs[t], $sformatf("output count %0d, expected %0d",
                      seen.size(), n_outs[t]));
                for (int i = 0; i < n_outs[t] && i < seen.size(); i++) begin
                        check(seen[i] == exp_outs[t][i],
                              $sformatf("output %0d is %h, expected %h", i, seen[i],
                                        exp_outs[t][i]));
                end
                check(num_inst == exp_num[t], $sformatf("num_inst %0d, expected %0d",
                      num_inst, exp_num[t]));
                check(num_inst == num_at_halt, "num_inst moved after halt");
                if (mem_addr[t] >= 0) begin
                        check(dmem[mem_addr[t]] == mem_val[t],
                              $sformatf("dmem[%0d] is %h, expected %h", mem_addr[t],
                                        dmem[mem_addr[t]], mem_val[t]));
                end
                if (test_errs != 0) failed_tests++;
                $display("test %0d %s: %s", t, names[t], (test_errs == 0) ? "ok" : "FAILED");
        endtask

        initial begin
                clk          = 1'b0;
                reset_n      = 1'b1;
                i_data       = '0;
                d_rdata      = '0;
                errors       = 0;
                failed_tests = 0;
                lfsr         = 16'd6550;
                build_table();
                for (int t = 0; t < NUM_TESTS; t++) begin
                        run_test(t);
                end
                $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests,
                         errors);
                if (errors == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
        input  word_t   i_a,
        input  word_t   i_b,
        input  alu_op_e i_op,
        output word_t   o_result,
        output logic    o_equal
);

        always_comb begin
                case (i_op)
                        ALU_ADD: o_result = i_a + i_b;  // wraps mod 2^16
                        ALU_SUB: o_result = i_a - i_b;
                        ALU_AND: o_result = i_a & i_b;
                        ALU_OR:  o_result = i_a | i_b;
                        default: o_result = '0;
                endcase
        end

        assign o_equal = (i_a == i_b);  // branch compare

endmodule

`default_nettype wire

// File: verilog/control_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module control_decoder import cpu_pkg::*; (
        input  word_t i_instr,
        output ctrl_t o_ctrl
);

        opcode_e opcode;
        func_e   func;

        assign opcode = opcode_e'(i_instr[OPCODE_MSB -: $bits(opcode_e)]);
        assign func   = func_e'(i_instr[$bits(func_e)-1:0]);

        always_comb begin
                o_ctrl = '0;    // unknown encodings stay a bubble
                case (opcode)
                        RTYPE: begin
                                case (func)
                                        ADD, SUB, AND, ORR: begin
                                                // func 0..3 line up with the alu encoding
                                                o_ctrl.alu_op    = alu_op_e'(func[1:0]);
                                                o_ctrl.reg_write = 1'b1;
                                                o_ctrl.dest_rd   = 1'b1;
                                        end
                                        WWD:     o_ctrl.is_wwd  = 1'b1;
                                        HLT:     o_ctrl.is_halt = 1'b1;
                                        default: o_ctrl = '0;
                                endcase
                        end
                        ADI: begin
                                o_ctrl.alu_op      = ALU_ADD;
                                o_ctrl.alu_src_imm = 1'b1;
                                o_ctrl.reg_write   = 1'b1;
                        end
                        LWD: begin
                                o_ctrl.alu_op      = ALU_ADD;   // rs + offset
                                o_ctrl.alu_src_imm = 1'b1;
                                o_ctrl.reg_write   = 1'b1;
                                o_ctrl.wb_src      = WB_MEM;
                                o_ctrl.mem_read    = 1'b1;
                        end
                        SWD: begin
                                o_ctrl.alu_op      = ALU_ADD;
                                o_ctrl.alu_src_imm = 1'b1;
                                o_ctrl.mem_write   = 1'b1;
                        end
                        BNE:     o_ctrl.is_branch = 1'b1;
                        BEQ: begin
                                o_ctrl.is_branch = 1'b1;
                                o_ctrl.branch_eq = 1'b1;
                        end
                        JMP:     o_ctrl.is_jump = 1'b1;
                        default: o_ctrl = '0;
                endcase
        end

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

        // ----------------------------------------
        // sizes and instruction fields
        // ----------------------------------------
        localparam int WORD_SIZE  = 16;
        localparam int NUM_REGS   = 4;
        localparam int OPCODE_MSB = 15;
        localparam int RS_LSB     = 10;
        localparam int RT_LSB     = 8;
        localparam int RD_LSB     = 6;
        localparam int IMM_WIDTH  = 8;

        typedef logic [WORD_SIZE-1:0]        word_t;
        typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

        // RTYPE with an undefined function code decodes to a bubble
        localparam word_t NOP_INSTR = 16'hf03f;

        typedef enum logic [3:0] {
                BNE   = 4'd0,
                BEQ   = 4'd1,
                ADI   = 4'd4,
                LWD   = 4'd7,
                SWD   = 4'd8,
                JMP   = 4'd9,
                RTYPE = 4'd15
        } opcode_e;

        typedef enum logic [5:0] {
                ADD = 6'd0,
                SUB = 6'd1,
                AND = 6'd2,
                ORR = 6'd3,
                WWD = 6'd28,
                HLT = 6'd29
        } func_e;

        typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_e;

        typedef enum logic {WB_ALU, WB_MEM} wb_src_e;

        // all zero is a bubble
        typedef struct packed {
                alu_op_e alu_op;
                logic    alu_src_imm;
                logic    reg_write;
                wb_src_e wb_src;
                logic    mem_read;
                logic    mem_write;
                logic    is_branch;
                logic    branch_eq;   // beq when set, bne otherwise
                logic    is_jump;
                logic    is_wwd;
                logic    is_halt;
                logic    dest_rd;     // write rd instead of rt
        } ctrl_t;

        typedef struct packed {
                logic  read;
                logic  write;
                word_t address;
                word_t wdata;
        } dmem_req_t;

endpackage

`default_nettype wire

// File: verilog/cpu_top.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
        input  logic      i_clk,
        input  logic      i_reset_n,
        input  word_t     i_i_data,
        output word_t     o_i_address,
        output dmem_req_t o_dmem,
        input  word_t     i_d_rdata,
        output word_t     o_output_port,
        output logic      o_output_valid,
        output logic      o_halted,
        output word_t     o_num_inst
);

        word_t     instr_id;
        ctrl_t     ctrl_id;
        reg_addr_t rs_id;
        reg_addr_t rt_id;
        logic      uses_rs;
        logic      uses_rt;
        reg_addr_t dest_ex;
        reg_addr_t dest_mem;
        logic      regwr_ex;
        logic      regwr_mem;
        logic      branch_taken;
        logic      jump_id;
        logic      stall_id;
        logic      flush_ifid;
        logic      flush_idex;

        datapath u_datapath (
                .i_clk          (i_clk),
                .i_reset_n      (i_reset_n),
                .o_i_address    (o_i_address),
                .i_i_data       (i_i_data),
                .o_dmem         (o_dmem),
                .i_d_rdata      (i_d_rdata),
                .o_output_port  (o_output_port),
                .o_output_valid (o_output_valid),
                .o_halted       (o_halted),
                .o_num_inst     (o_num_inst),
                .o_instr_id     (instr_id),
                .i_ctrl_id      (ctrl_id),
                .o_rs_id        (rs_id),
                .o_rt_id        (rt_id),
                .o_uses_rs_id   (uses_rs),
                .o_uses_rt_id   (uses_rt),
                .o_dest_ex      (dest_ex),
                .o_dest_mem     (dest_mem),
                .o_regwr_ex     (regwr_ex),
                .o_regwr_mem    (regwr_mem),
                .o_branch_taken (branch_taken),
                .o_jump_id      (jump_id),
                .i_stall_id     (stall_id),
                .i_flush_ifid   (flush_ifid),
                .i_flush_idex   (flush_idex)
        );

        control_decoder u_control_decoder (
                .i_instr (instr_id),
                .o_ctrl  (ctrl_id)
        );

        hazard_unit u_hazard_unit (
                .i_rs           (rs_id),
                .i_rt           (rt_id),
                .i_uses_rs      (uses_rs),
                .i_uses_rt      (uses_rt),
                .i_dest_ex      (dest_ex),
                .i_regwr_ex     (regwr_ex),
                .i_dest_mem     (dest_mem),
                .i_regwr_mem    (regwr_mem),
                .i_branch_taken (branch_taken),
                .i_jump         (jump_id),
                .o_stall_id     (stall_id),
                .o_flush_ifid   (flush_ifid),
                .o_flush_idex   (flush_idex)
        );

endmodule

`default_nettype wire

// File: verilog/datapath.sv
`default_nettype none
`timescale 1ns/1ps

module datapath import cpu_pkg::*; (
        input  logic      i_clk,
        input  logic      i_reset_n,
        // memories and output
        output word_t     o_i_address,
        input  word_t     i_i_data,
        output dmem_req_t o_dmem,
        input  word_t     i_d_rdata,
        output word_t     o_output_port,
        output logic      o_output_valid,
        output logic      o_halted,
        output word_t     o_num_inst,
        // decoder
        output word_t     o_instr_id,
        input  ctrl_t     i_ctrl_id,
        // hazard unit
        output reg_addr_t o_rs_id,
        output reg_addr_t o_rt_id,
        output logic      o_uses_rs_id,
        output logic      o_uses_rt_id,
        output reg_addr_t o_dest_ex,
        output reg_addr_t o_dest_mem,
        output logic      o_regwr_ex,
        output logic      o_regwr_mem,
        output logic      o_branch_taken,
        output logic      o_jump_id,
        input  logic      i_stall_id,
        input  logic      i_flush_ifid,
        input  logic      i_flush_idex
);

        typedef struct packed {
                ctrl_t     ctrl;
                word_t     rdata1;
                word_t     rdata2;
                word_t     imm;
                word_t     target;      // pc + 1 + imm
                reg_addr_t dest;
        } idex_t;

        typedef struct packed {
                ctrl_t     ctrl;
                word_t     result;
                word_t     wdata;
                reg_addr_t dest;
        } exmem_t;

        typedef struct packed {
                ctrl_t     ctrl;
                word_t     result;
                word_t     mdata;
                reg_addr_t dest;
        } memwb_t;

        word_t     pc;
        word_t     pc_id;
        word_t     instr_id;
        logic      fetch_halted;
        logic      halt_fetch;
        word_t     rdata1;
        word_t     rdata2;
        word_t     jump_target;
        reg_addr_t rd_id;
        idex_t     id_next;
        idex_t     ex;
        word_t     alu_b;
        word_t     alu_result;
        logic      alu_equal;
        exmem_t    ex_next;
        exmem_t    mem;
        memwb_t    wb;
        word_t     wb_data;

        // ----------------------------------------
        // fetch
        // ----------------------------------------
        assign o_i_address = pc;
        assign halt_fetch  = i_ctrl_id.is_halt | fetch_halted;

        always_ff @(posedge i_clk) begin
                if (i_reset_n) begin
                        pc <= '0;
                end else if (i_flush_idex) begin
                        pc <= ex.target;        // taken branch wins over jump
                end else if (i_flush_ifid) begin
                        pc <= jump_target;
                end else if (!i_stall_id && !halt_fetch) begin
                        pc <= pc + 16'd1;
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_reset_n) begin
                        instr_id     <= NOP_INSTR;
                        fetch_halted <= 1'b0;
                end else begin
                        if (i_flush_ifid || halt_fetch) begin
                                instr_id <= NOP_INSTR;
                        end else if (!i_stall_id) begin
                                instr_id <= i_i_data;
                        end
                        if (i_ctrl_id.is_halt && !i_flush_idex) begin
                                fetch_halted <= 1'b1;   // no more fetches after hlt
                        end
                end
        end

        always_ff @(posedge i_clk) begin
                if (!i_stall_id) begin
                        pc_id <= pc;
                end
        end

        // ----------------------------------------
        // decode
        // ----------------------------------------
        assign o_instr_id = instr_id;
        assign o_rs_id    = instr_id[RS_LSB +: $bits(reg_addr_t)];
        assign o_rt_id    = instr_id[RT_LSB +: $bits(reg_addr_t)];
        assign rd_id      = instr_id[RD_LSB +: $bits(reg_addr_t)];
        assign o_jump_id  = i_ctrl_id.is_jump;
        assign jump_target = {pc_id[OPCODE_MSB -: $bits(opcode_e)],
                              instr_id[OPCODE_MSB-$bits(opcode_e):0]};

        assign o_uses_rs_id = i_ctrl_id.reg_write | i_ctrl_id.mem_write |
                              i_ctrl_id.is_branch | i_ctrl_id.is_wwd;
        assign o_uses_rt_id = (i_ctrl_id.reg_write & ~i_ctrl_id.alu_src_imm) |
                              i_ctrl_id.mem_write | i_ctrl_id.is_branch;

        register_file u_register_file (
                .i_clk     (i_clk),
                .i_reset_n (i_reset_n),
                .i_raddr1  (o_rs_id),
                .i_raddr2  (o_rt_id),
                .o_rdata1  (rdata1),
                .o_rdata2  (rdata2),
                .i_we      (wb.ctrl.reg_write),
                .i_waddr   (wb.dest),
                .i_wdata   (wb_data)
        );

        always_comb begin
                id_next.ctrl   = i_ctrl_id;
                id_next.rdata1 = rdata1;
                id_next.rdata2 = rdata2;
                id_next.imm    = {{(WORD_SIZE-IMM_WIDTH){instr_id[IMM_WIDTH-1]}},
                                  instr_id[IMM_WIDTH-1:0]};
                id_next.target = pc_id + 16'd1 + id_next.imm;
                id_next.dest   = i_ctrl_id.dest_rd ? rd_id : o_rt_id;
        end

        always_ff @(posedge i_clk) begin
                if (i_reset_n) begin
                        ex.ctrl <= '0;
                end else begin
                        ex <= id_next;
                        if (i_flush_idex || i_stall_id) begin
                                ex.ctrl <= '0;  // bubble
                        end
                end
        end

        // ----------------------------------------
        // execute
        // ----------------------------------------
        assign alu_b = ex.ctrl.alu_src_imm ? ex.imm : ex.rdata2;

        alu u_alu (
                .i_a      (ex.rdata1),
                .i_b      (alu_b),
                .i_op     (ex.ctrl.alu_op),
                .o_result (alu_result),
                .o_equal  (alu_equal)
        );

        assign o_branch_taken = ex.ctrl.is_branch && (alu_equal == ex.ctrl.branch_eq);
        assign o_dest_ex      = ex.dest;
        assign o_regwr_ex     = ex.ctrl.reg_write;

        always_comb begin
                ex_next.ctrl   = ex.ctrl;
                ex_next.result = ex.ctrl.is_wwd ? ex.rdata1 : alu_result;  // wwd passes rs
                ex_next.wdata  = ex.rdata2;
                ex_next.dest   = ex.dest;
        end

        always_ff @(posedge i_clk) begin
                if (i_reset_n) begin
                        mem.ctrl <= '0;
                end else begin
                        mem <= ex_next;
                end
        end

        // ----------------------------------------
        // memory
        // ----------------------------------------
        assign o_dmem = '{read:    mem.ctrl.mem_read,
                          write:   mem.ctrl.mem_write,
                          address: mem.result,
                          wdata:   mem.wdata};
        assign o_dest_mem  = mem.dest;
        assign o_regwr_mem = mem.ctrl.reg_write;

        always_ff @(posedge i_clk) begin
                if (i_reset_n) begin
                        wb.ctrl <= '0;
                end else begin
                        wb.ctrl   <= mem.ctrl;
                        wb.result <= mem.result;
                        wb.mdata  <= i_d_rdata;
                        wb.dest   <= mem.dest;
                end
        end

        // ----------------------------------------
        // write-back
        // ----------------------------------------
        assign wb_data = (wb.ctrl.wb_src == WB_MEM) ? wb.mdata : wb.result;

        always_ff @(posedge i_clk) begin
                if (i_reset_n) begin
                        o_output_valid <= 1'b0;
                        o_halted       <= 1'b0;
                        o_num_inst     <= '0;
                end else begin
                        o_output_valid <= wb.ctrl.is_wwd;
                        if (wb.ctrl.is_halt) begin
                                o_halted <= 1'b1;       // sticky until reset
                        end
                        if (wb.ctrl != '0) begin
                                o_num_inst <= o_num_inst + 16'd1;
                        end
                end
        end

        always_ff @(posedge i_clk) begin
                if (wb.ctrl.is_wwd) begin
                        o_output_port <= wb.result;
                end
        end

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
`default_nettype none
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
        input  reg_addr_t i_rs,
        input  reg_addr_t i_rt,
        input  logic      i_uses_rs,
        input  logic      i_uses_rt,
        input  reg_addr_t i_dest_ex,
        input  logic      i_regwr_ex,
        input  reg_addr_t i_dest_mem,
        input  logic      i_regwr_mem,
        input  logic      i_branch_taken,
        input  logic      i_jump,
        output logic      o_stall_id,
        output logic      o_flush_ifid,
        output logic      o_flush_idex
);

        logic dep_ex;
        logic dep_mem;

        // r0 is an ordinary register here
        function automatic logic reads_dest(input reg_addr_t dest, input logic we);
                return we && ((i_uses_rs && i_rs == dest) || (i_uses_rt && i_rt == dest));
        endfunction

        always_comb begin
                dep_ex  = reads_dest(i_dest_ex, i_regwr_ex);
                dep_mem = reads_dest(i_dest_mem, i_regwr_mem);   // wb is covered by write-through
        end

        assign o_flush_idex = i_branch_taken;
        assign o_flush_ifid = i_branch_taken | i_jump;
        assign o_stall_id   = (dep_ex | dep_mem) & ~o_flush_ifid;

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`default_nettype none
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
        input  logic      i_clk,
        input  logic      i_reset_n,
        input  reg_addr_t i_raddr1,
        input  reg_addr_t i_raddr2,
        output word_t     o_rdata1,
        output word_t     o_rdata2,
        input  logic      i_we,
        input  reg_addr_t i_waddr,
        input  word_t     i_wdata
);

        word_t regs [NUM_REGS];

        always_ff @(posedge i_clk) begin
                if (i_reset_n) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (i_we) begin
                        regs[i_waddr] <= i_wdata;
                end
        end

        // write-through so decode sees the value retiring this cycle
        assign o_rdata1 = (i_we && i_waddr == i_raddr1) ? i_wdata : regs[i_raddr1];
        assign o_rdata2 = (i_we && i_waddr == i_raddr2) ? i_wdata : regs[i_raddr2];

endmodule

`default_nettype wire
